/* src/cps_pkg.sv */
// Shared widths, vector typedefs, slot indices and the arbiter state enum
package cps_pkg;

    // SDRAM word address, enough for a 4M word bank
    localparam int SDRAM_AW = 22;

    // Bank data width
    localparam int ROM_DW = 16;

    // Raster counters cover up to 512 positions
    localparam int RASTER_W = 9;

    // ROM clients that share the read bank
    localparam int SLOT_N = 3;

    // Bit positions in a slot vector
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_GFX = 1;
    localparam int SLOT_SND = 2;

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [ROM_DW-1:0]   rom_word_t;
    typedef logic [RASTER_W-1:0] raster_pos_t;
    typedef logic [SLOT_N-1:0]   slot_vec_t;

    // Bank read sequence
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_t;

endpackage

/* src/video_timing.sv */
// Raster timing block with pixel clock enables, dump counters, blanking and sync
module video_timing #(
    parameter int H_VISIBLE = 384,
    parameter int H_TOTAL = 512,
    parameter int V_VISIBLE = 224,
    parameter int V_TOTAL = 262
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic                pxl2_cen,
    output logic                pxl_cen,
    output cps_pkg::raster_pos_t hdump,
    output cps_pkg::raster_pos_t vdump,
    output logic                hb,
    output logic                vb,
    output logic                hs,
    output logic                vs
);

    // Decode points in counter width
    localparam cps_pkg::raster_pos_t H_LAST = cps_pkg::raster_pos_t'(H_TOTAL - 1);
    localparam cps_pkg::raster_pos_t V_LAST = cps_pkg::raster_pos_t'(V_TOTAL - 1);
    localparam cps_pkg::raster_pos_t H_VIS = cps_pkg::raster_pos_t'(H_VISIBLE);
    localparam cps_pkg::raster_pos_t V_VIS = cps_pkg::raster_pos_t'(V_VISIBLE);

    // Sync pulses sit a little into the blanking
    localparam cps_pkg::raster_pos_t HS_START = cps_pkg::raster_pos_t'(H_VISIBLE + 2);
    localparam cps_pkg::raster_pos_t HS_END = cps_pkg::raster_pos_t'(H_VISIBLE + 6);
    localparam cps_pkg::raster_pos_t VS_START = cps_pkg::raster_pos_t'(V_VISIBLE + 1);
    localparam cps_pkg::raster_pos_t VS_END = cps_pkg::raster_pos_t'(V_VISIBLE + 3);

    logic [1:0] div;

    // Divide by 4, pxl2_cen on odd counts and pxl_cen on the last one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div      <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            div      <= div + 2'd1;
            pxl2_cen <= div[0];
            pxl_cen  <= (div == 2'd3);
        end
    end

    // Dump counters move one pixel per pxl_cen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == H_LAST) begin
                hdump <= '0;
                if (vdump == V_LAST) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Blanking from the visible area limits
    assign hb = (hdump >= H_VIS);
    assign vb = (vdump >= V_VIS);

    // Four pixel hsync and two line vsync
    assign hs = (hdump >= HS_START) && (hdump < HS_END);
    assign vs = (vdump >= VS_START) && (vdump < VS_END);

endmodule

/* src/rom_slot.sv */
// One-word ROM request slot with hit detection and a single pending request
module rom_slot (
    input  logic                 clk,
    input  logic                 rst_n,
    // Client side
    input  logic                 cs,
    input  cps_pkg::sdram_addr_t addr,
    output cps_pkg::rom_word_t   data,
    output logic                 ok,
    // Arbiter side
    output logic                 req,
    output cps_pkg::sdram_addr_t req_addr,
    input  logic                 done,
    input  cps_pkg::rom_word_t   rd_data
);

    // Cached pair from the last completed read
    cps_pkg::sdram_addr_t cached_addr;
    cps_pkg::rom_word_t   cached_data;
    logic                 valid;

    logic hit;
    logic miss;

    assign hit = valid && (addr == cached_addr);

    // Only one request in flight per slot
    assign miss = cs && !hit && !req;

    // Word payload, loaded only when a read completes
    always_ff @(posedge clk) begin
        if (done) begin
            cached_addr <= req_addr;
            cached_data <= rd_data;
        end
    end

    // Request address is captured on the miss and held until done
    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (done) begin
                valid <= 1'b1;
                req   <= 1'b0;
            end else if (miss) begin
                req <= 1'b1;
            end
        end
    end

    // A changed address drops ok right away
    assign ok   = cs && hit;
    assign data = cached_data;

endmodule

/* src/sdram_arbiter.sv */
// Fixed-priority arbiter for the slot requests and the SDRAM bank read handshake
module sdram_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vb,
    // Slot requests
    input  cps_pkg::slot_vec_t   req,
    input  cps_pkg::sdram_addr_t main_addr,
    input  cps_pkg::sdram_addr_t gfx_addr,
    input  cps_pkg::sdram_addr_t snd_addr,
    output cps_pkg::rom_word_t   rd_data,
    output cps_pkg::slot_vec_t   done,
    // Bank
    output logic                 ba_rd,
    output cps_pkg::sdram_addr_t ba_addr,
    input  logic                 ba_ack,
    input  logic                 ba_dok,
    input  cps_pkg::rom_word_t   data_read
);

    cps_pkg::arb_state_t  state;
    cps_pkg::slot_vec_t   grant;
    cps_pkg::slot_vec_t   pending;
    cps_pkg::slot_vec_t   winner;
    cps_pkg::sdram_addr_t win_addr;

    // Graphics first during active video, CPU and sound first in vblank
    function automatic cps_pkg::slot_vec_t pick(
        input cps_pkg::slot_vec_t pend,
        input logic               blank
    );
        cps_pkg::slot_vec_t win;
        win = '0;
        if (blank) begin
            if (pend[cps_pkg::SLOT_MAIN]) begin
                win[cps_pkg::SLOT_MAIN] = 1'b1;
            end else if (pend[cps_pkg::SLOT_SND]) begin
                win[cps_pkg::SLOT_SND] = 1'b1;
            end else if (pend[cps_pkg::SLOT_GFX]) begin
                win[cps_pkg::SLOT_GFX] = 1'b1;
            end
        end else begin
            if (pend[cps_pkg::SLOT_GFX]) begin
                win[cps_pkg::SLOT_GFX] = 1'b1;
            end else if (pend[cps_pkg::SLOT_MAIN]) begin
                win[cps_pkg::SLOT_MAIN] = 1'b1;
            end else if (pend[cps_pkg::SLOT_SND]) begin
                win[cps_pkg::SLOT_SND] = 1'b1;
            end
        end
        return win;
    endfunction

    // The slot being served this cycle still shows req, so mask it
    assign pending = req & ~done;
    assign winner  = pick(pending, vb);

    always_comb begin
        if (winner[cps_pkg::SLOT_GFX]) begin
            win_addr = gfx_addr;
        end else if (winner[cps_pkg::SLOT_MAIN]) begin
            win_addr = main_addr;
        end else begin
            win_addr = snd_addr;
        end
    end

    // Address and data words
    always_ff @(posedge clk) begin
        if (state == cps_pkg::ARB_IDLE && pending != '0) begin
            ba_addr <= win_addr;
        end
        if (state == cps_pkg::ARB_WAIT_DATA && ba_dok) begin
            rd_data <= data_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cps_pkg::ARB_IDLE;
            grant <= '0;
            ba_rd <= 1'b0;
            done  <= '0;
        end else begin
            done <= '0;
            case (state)
                cps_pkg::ARB_IDLE: begin
                    if (pending != '0) begin
                        grant <= winner;
                        ba_rd <= 1'b1;
                        state <= cps_pkg::ARB_WAIT_ACK;
                    end
                end
                cps_pkg::ARB_WAIT_ACK: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= cps_pkg::ARB_WAIT_DATA;
                    end
                end
                cps_pkg::ARB_WAIT_DATA: begin
                    // Data goes back one cycle after dok
                    if (ba_dok) begin
                        done  <= grant;
                        state <= cps_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= cps_pkg::ARB_IDLE;
                    ba_rd <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* src/cps_game.sv */
// Game top level joining raster timing, three ROM slots and the SDRAM arbiter
module cps_game #(
    parameter int H_VISIBLE = 384,
    parameter int H_TOTAL = 512,
    parameter int V_VISIBLE = 224,
    parameter int V_TOTAL = 262
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Main CPU program ROM
    input  logic                 main_rom_cs,
    input  cps_pkg::sdram_addr_t main_rom_addr,
    output cps_pkg::rom_word_t   main_rom_data,
    output logic                 main_rom_ok,
    // Graphics ROM
    input  logic                 gfx_rom_cs,
    input  cps_pkg::sdram_addr_t gfx_rom_addr,
    output cps_pkg::rom_word_t   gfx_rom_data,
    output logic                 gfx_rom_ok,
    // Sound sample ROM
    input  logic                 snd_rom_cs,
    input  cps_pkg::sdram_addr_t snd_rom_addr,
    output cps_pkg::rom_word_t   snd_rom_data,
    output logic                 snd_rom_ok,
    // SDRAM read bank
    output logic                 ba_rd,
    output cps_pkg::sdram_addr_t ba_addr,
    input  logic                 ba_ack,
    input  logic                 ba_dok,
    input  cps_pkg::rom_word_t   data_read,
    // Raster
    output logic                 pxl2_cen,
    output logic                 pxl_cen,
    output cps_pkg::raster_pos_t hdump,
    output cps_pkg::raster_pos_t vdump,
    output logic                 hb,
    output logic                 vb,
    output logic                 hs,
    output logic                 vs
);

    cps_pkg::slot_vec_t   slot_req;
    cps_pkg::slot_vec_t   slot_done;
    cps_pkg::rom_word_t   rd_data;
    cps_pkg::sdram_addr_t main_req_addr;
    cps_pkg::sdram_addr_t gfx_req_addr;
    cps_pkg::sdram_addr_t snd_req_addr;

    video_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_TOTAL   (H_TOTAL),
        .V_VISIBLE (V_VISIBLE),
        .V_TOTAL   (V_TOTAL)
    ) u_timing (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .hb       (hb),
        .vb       (vb),
        .hs       (hs),
        .vs       (vs)
    );

    rom_slot u_main_slot (
        .clk      (clk),
        .rst_n    (rst_n),
        .cs       (main_rom_cs),
        .addr     (main_rom_addr),
        .data     (main_rom_data),
        .ok       (main_rom_ok),
        .req      (slot_req[cps_pkg::SLOT_MAIN]),
        .req_addr (main_req_addr),
        .done     (slot_done[cps_pkg::SLOT_MAIN]),
        .rd_data  (rd_data)
    );

    rom_slot u_gfx_slot (
        .clk      (clk),
        .rst_n    (rst_n),
        .cs       (gfx_rom_cs),
        .addr     (gfx_rom_addr),
        .data     (gfx_rom_data),
        .ok       (gfx_rom_ok),
        .req      (slot_req[cps_pkg::SLOT_GFX]),
        .req_addr (gfx_req_addr),
        .done     (slot_done[cps_pkg::SLOT_GFX]),
        .rd_data  (rd_data)
    );

    rom_slot u_snd_slot (
        .clk      (clk),
        .rst_n    (rst_n),
        .cs       (snd_rom_cs),
        .addr     (snd_rom_addr),
        .data     (snd_rom_data),
        .ok       (snd_rom_ok),
        .req      (slot_req[cps_pkg::SLOT_SND]),
        .req_addr (snd_req_addr),
        .done     (slot_done[cps_pkg::SLOT_SND]),
        .rd_data  (rd_data)
    );

    // Vertical blank reorders the bank priority
    sdram_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .vb        (vb),
        .req       (slot_req),
        .main_addr (main_req_addr),
        .gfx_addr  (gfx_req_addr),
        .snd_addr  (snd_req_addr),
        .rd_data   (rd_data),
        .done      (slot_done),
        .ba_rd     (ba_rd),
        .ba_addr   (ba_addr),
        .ba_ack    (ba_ack),
        .ba_dok    (ba_dok),
        .data_read (data_read)
    );

endmodule

/* tests/cps_game_asserts.sv */
// Concurrent checks on the bank read handshake, client ok flags and horizontal blanking
module cps_game_asserts #(
    parameter int H_VISIBLE = 384
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 ba_rd,
    input cps_pkg::sdram_addr_t ba_addr,
    input logic                 ba_ack,
    input logic                 main_rom_cs,
    input logic                 main_rom_ok,
    input logic                 gfx_rom_cs,
    input logic                 gfx_rom_ok,
    input logic                 snd_rom_cs,
    input logic                 snd_rom_ok,
    input cps_pkg::raster_pos_t hdump,
    input logic                 hb
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // Read request holds with a fixed address until the bank takes it
    a_rd_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr)
    ) else begin
        assert_fails++;
        $error("ba_rd dropped or ba_addr moved before ba_ack");
    end

    a_ok_needs_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(main_rom_ok && !main_rom_cs) && !(gfx_rom_ok && !gfx_rom_cs)
            && !(snd_rom_ok && !snd_rom_cs)
    ) else begin
        assert_fails++;
        $error("a ROM ok flag is high while its cs is low");
    end

    a_hb_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        hb |-> hdump >= H_VISIBLE
    ) else begin
        assert_fails++;
        $error("hb high at hdump %0d", hdump);
    end

    // No read starts in the first cycle out of reset
    a_rd_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !ba_rd
    ) else begin
        assert_fails++;
        $error("ba_rd high right after reset release");
    end

endmodule

/* tests/tb_cps_game.sv */
// Testbench for cps_game with random ROM clients, a bank model and raster reference checks
module tb_cps_game;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_VISIBLE = 16;
    localparam int H_TOTAL = 24;
    localparam int V_VISIBLE = 6;
    localparam int V_TOTAL = 10;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int N_REQ = 300;
    // Worst case for one request with all three clients queued on a slow bank
    localparam int REQ_CYCLES = 40;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * 4;
    localparam int RUN_CYCLES = N_REQ * REQ_CYCLES + 2 * FRAME_CYCLES + RESET_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic [2:0]           cs_q;
    cps_pkg::sdram_addr_t addr_q [3];
    cps_pkg::rom_word_t   data_w [3];
    logic [2:0]           ok_w;
    logic                 ba_rd;
    cps_pkg::sdram_addr_t ba_addr;
    logic                 ba_ack;
    logic                 ba_dok;
    cps_pkg::rom_word_t   data_read;
    logic                 pxl2_cen;
    logic                 pxl_cen;
    cps_pkg::raster_pos_t hdump;
    cps_pkg::raster_pos_t vdump;
    logic                 hb;
    logic                 vb;
    logic                 hs;
    logic                 vs;

    integer seed = 32'h710e_9970;
    string  names [3] = '{"main_rom", "gfx_rom", "snd_rom"};
    int     value_errors = 0;
    int     other_errors = 0;
    int     grants = 0;
    int     acks = 0;
    int     doks = 0;
    int     fills = 0;
    int     hits = 0;
    int     cycle = 0;
    int     last_cen;
    // Monitor view of each client's outstanding miss
    logic   granted [3];
    int     wait_cnt [3];
    logic   vb_prev;
    logic   rd_prev;
    logic   pxl2_prev;
    cps_pkg::raster_pos_t h_model;
    cps_pkg::raster_pos_t v_model;

    cps_game #(
        .H_VISIBLE (H_VISIBLE), .H_TOTAL (H_TOTAL),
        .V_VISIBLE (V_VISIBLE), .V_TOTAL (V_TOTAL)
    ) i_dut (
        .clk (clk), .rst_n (rst_n),
        .main_rom_cs (cs_q[0]), .main_rom_addr (addr_q[0]),
        .main_rom_data (data_w[0]), .main_rom_ok (ok_w[0]),
        .gfx_rom_cs (cs_q[1]), .gfx_rom_addr (addr_q[1]),
        .gfx_rom_data (data_w[1]), .gfx_rom_ok (ok_w[1]),
        .snd_rom_cs (cs_q[2]), .snd_rom_addr (addr_q[2]),
        .snd_rom_data (data_w[2]), .snd_rom_ok (ok_w[2]),
        .ba_rd (ba_rd), .ba_addr (ba_addr), .ba_ack (ba_ack),
        .ba_dok (ba_dok), .data_read (data_read),
        .pxl2_cen (pxl2_cen), .pxl_cen (pxl_cen), .hdump (hdump), .vdump (vdump),
        .hb (hb), .vb (vb), .hs (hs), .vs (vs)
    );

    bind cps_game cps_game_asserts #(.H_VISIBLE (H_VISIBLE)) u_asserts (
        .clk (clk), .rst_n (rst_n), .ba_rd (ba_rd), .ba_addr (ba_addr), .ba_ack (ba_ack),
        .main_rom_cs (main_rom_cs), .main_rom_ok (main_rom_ok),
        .gfx_rom_cs (gfx_rom_cs), .gfx_rom_ok (gfx_rom_ok),
        .snd_rom_cs (snd_rom_cs), .snd_rom_ok (snd_rom_ok),
        .hdump (hdump), .hb (hb)
    );

    // Bank contents, low address word folded with the six top address bits
    function automatic cps_pkg::rom_word_t bank_word(input cps_pkg::sdram_addr_t a);
        return a[15:0] ^ {10'd0, a[21:16]};
    endfunction

    // Clients live in separate 1M word regions, main then gfx then snd
    function automatic int client_of(input cps_pkg::sdram_addr_t a);
        return int'(a[21:20]);
    endfunction

    // Rank 0 wins; gfx leads in active video, main then snd in vblank
    function automatic int rank_of(input int c, input logic blank);
        if (blank) begin
            return (c == 0) ? 0 : (c == 2) ? 1 : 2;
        end
        return (c == 1) ? 0 : (c == 0) ? 1 : 2;
    endfunction

    task automatic check_word(input string name, input cps_pkg::rom_word_t got,
                              input cps_pkg::rom_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %t %s got %h expected %h", $realtime, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cps_pkg::sdram_addr_t got,
                              input cps_pkg::sdram_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %t %s got %h expected %h", $realtime, name, got, exp);
        end
    endtask

    task automatic check_pos(input string name, input cps_pkg::raster_pos_t got,
                             input cps_pkg::raster_pos_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %t %s got %0d expected %0d", $realtime, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %t %s got %b expected %b", $realtime, name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        other_errors++;
        $display("%t %s", $realtime, msg);
    endtask

    // Random address out of eight, held until ok, then a short idle
    task automatic run_client(input int c);
        cps_pkg::sdram_addr_t a;
        cps_pkg::sdram_addr_t cached;
        logic cache_ok;
        logic expect_hit;
        int   idle;
        cache_ok = 1'b0;
        cached = '0;
        repeat (N_REQ) begin
            a = cps_pkg::sdram_addr_t'(c) << 20;
            a = a + cps_pkg::sdram_addr_t'(($unsigned($random(seed)) % 8) * 22'h2345);
            expect_hit = cache_ok && (a == cached);
            cs_q[c] <= 1'b1;
            addr_q[c] <= a;
            @(posedge clk);
            check_bit({names[c], "_ok"}, ok_w[c], expect_hit);
            hits += int'(expect_hit);
            while (ok_w[c] !== 1'b1) @(posedge clk);
            cached = a;
            cache_ok = 1'b1;
            idle = $unsigned($random(seed)) % 4;
            if (idle > 0) begin
                cs_q[c] <= 1'b0;
                repeat (idle) @(posedge clk);
            end
        end
        cs_q[c] <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One read at a time, ack after 0 to 3 cycles and dok 1 to 4 cycles later
    initial begin : bank_model
        cps_pkg::sdram_addr_t a;
        int ack_wait;
        int dok_wait;
        ba_ack = 1'b0;
        ba_dok = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (rst_n === 1'b1 && ba_rd === 1'b1) begin
                a = ba_addr;
                ack_wait = $unsigned($random(seed)) % 4;
                dok_wait = 1 + $unsigned($random(seed)) % 4;
                repeat (ack_wait) @(posedge clk);
                ba_ack <= 1'b1;
                @(posedge clk);
                ba_ack <= 1'b0;
                repeat (dok_wait - 1) @(posedge clk);
                ba_dok <= 1'b1;
                data_read <= bank_word(a);
                @(posedge clk);
                ba_dok <= 1'b0;
                data_read <= cps_pkg::rom_word_t'($random(seed));
            end
        end
    end

    always @(posedge clk) begin : monitor
        int c;
        int best;
        int contenders;
        cycle++;
        if (rst_n !== 1'b1) begin
            // First edge still shows power-up values
            if (cycle > 1) begin
                check_bit("ba_rd", ba_rd, 1'b0);
                check_bit("pxl_cen", pxl_cen, 1'b0);
                check_bit("pxl2_cen", pxl2_cen, 1'b0);
                check_bit("hs", hs, 1'b0);
                check_bit("vs", vs, 1'b0);
                check_bit("rom_ok", |ok_w, 1'b0);
                check_pos("hdump", hdump, '0);
                check_pos("vdump", vdump, '0);
            end
            h_model = '0;
            v_model = '0;
            last_cen = -1;
            for (int k = 0; k < 3; k++) begin
                granted[k] = 1'b0;
                wait_cnt[k] = 0;
            end
        end else begin
            check_pos("hdump", hdump, h_model);
            check_pos("vdump", vdump, v_model);
            check_bit("hb", hb, h_model >= H_VISIBLE);
            check_bit("vb", vb, v_model >= V_VISIBLE);
            check_bit("hs", hs, h_model >= H_VISIBLE + 2 && h_model < H_VISIBLE + 6);
            check_bit("vs", vs, v_model >= V_VISIBLE + 1 && v_model < V_VISIBLE + 3);
            if (pxl_cen === 1'b1) begin
                if (last_cen >= 0 && cycle - last_cen != 4) begin
                    report_fault($sformatf("pxl_cen came %0d cycles after the last one",
                                           cycle - last_cen));
                end
                if (pxl2_cen !== 1'b1) begin
                    report_fault("pxl_cen pulsed without pxl2_cen");
                end
                last_cen = cycle;
                if (h_model == H_TOTAL - 1) begin
                    h_model = '0;
                    v_model = (v_model == V_TOTAL - 1) ? '0 : v_model + 1'b1;
                end else begin
                    h_model = h_model + 1'b1;
                end
            end
            if (last_cen >= 0 && pxl2_cen === pxl2_prev) begin
                report_fault("pxl2_cen did not alternate between cycles");
            end
            acks += int'(ba_ack === 1'b1);
            doks += int'(ba_dok === 1'b1);
            // A new grant shows as a rising ba_rd
            if (ba_rd === 1'b1 && rd_prev !== 1'b1) begin
                grants++;
                c = client_of(ba_addr);
                if (c > 2 || cs_q[c] !== 1'b1 || ok_w[c] === 1'b1 || granted[c]) begin
                    report_fault($sformatf("ba_rd for %h with no outstanding miss", ba_addr));
                end else begin
                    check_addr("ba_addr", ba_addr, addr_q[c]);
                    best = c;
                    contenders = 0;
                    for (int k = 0; k < 3; k++) begin
                        if (wait_cnt[k] >= 2) begin
                            contenders++;
                            if (rank_of(k, vb_prev) < rank_of(best, vb_prev)) begin
                                best = k;
                            end
                        end
                    end
                    if (contenders >= 2 && best != c) begin
                        report_fault($sformatf("%s was granted ahead of %s with vb %b",
                                               names[c], names[best], vb_prev));
                    end
                    granted[c] = 1'b1;
                end
            end
            for (int k = 0; k < 3; k++) begin
                if (ok_w[k] === 1'b1) begin
                    check_word({names[k], "_data"}, data_w[k], bank_word(addr_q[k]));
                    fills += int'(granted[k]);
                    granted[k] = 1'b0;
                    wait_cnt[k] = 0;
                end else if (cs_q[k] === 1'b1 && !granted[k]) begin
                    wait_cnt[k]++;
                end else begin
                    wait_cnt[k] = 0;
                end
            end
        end
        vb_prev = vb;
        rd_prev = ba_rd;
        pxl2_prev = pxl2_cen;
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a client never got its ok", RUN_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main_flow
        int assert_fails;
        $timeformat(-9, 0, " ns", 0);
        rst_n = 1'b0;
        cs_q = '0;
        addr_q = '{default: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        fork
            run_client(0);
            run_client(1);
            run_client(2);
        join
        repeat (8) @(posedge clk);
        if (acks != grants || doks != grants || fills != grants) begin
            report_fault($sformatf("bank counts differ, %0d grants %0d acks %0d doks %0d fills",
                                   grants, acks, doks, fills));
        end
        assert_fails = i_dut.u_asserts.assert_fails;
        $display({"Summary: %0d value errors, %0d other errors, %0d assertion errors, ",
                  "%0d grants, %0d hits"},
                 value_errors, other_errors, assert_fails, grants, hits);
        if (value_errors + other_errors + assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
src/cps_pkg.sv
src/video_timing.sv
src/rom_slot.sv
src/sdram_arbiter.sv
src/cps_game.sv
tests/cps_game_asserts.sv
tests/tb_cps_game.sv

/* Bender.yml */
package:
  name: cps_game

sources:
  - src/cps_pkg.sv
  - src/video_timing.sv
  - src/rom_slot.sv
  - src/sdram_arbiter.sv
  - src/cps_game.sv
  - target: test
    files:
      - tests/cps_game_asserts.sv
      - tests/tb_cps_game.sv
